// File: src.f
rob_pkg.sv
rob_dispatch.sv
rob_buffer.sv
rob_retire.sv
rob_core.sv
tb_clock_gen.sv
rob_core_tb.sv

// File: rob_core_tb.sv
// directed reorder buffer testbench covering order, branches, squash, traps and fullness
`timescale 1ns/1ps

module rob_core_tb;

  import rob_pkg::*;

  typedef struct packed {
    dispatch_t d;
    rob_id_t   id;
  } sb_rec_t;

  // cycle budgets per test and their sum for the watchdog
  localparam int BUDGET_RESET  = 10;
  localparam int BUDGET_ORDER  = 80;
  localparam int BUDGET_ONE    = 30;
  localparam int BUDGET_SQUASH = 60;
  localparam int BUDGET_FULL   = 3 * ROB_DEPTH + 40;
  localparam int WD_CYCLES     = BUDGET_RESET + BUDGET_ORDER + 8 * BUDGET_ONE +
                                 BUDGET_SQUASH + BUDGET_FULL + 200;

  logic        clk;
  logic        reset;
  logic        dispatch_valid;
  dispatch_t   dispatch_in;
  logic        alloc_valid;
  rob_id_t     alloc_robid;
  logic        rob_full;
  logic        wb_valid;
  wb_t         wb_in;
  pc_t         csr_tvec;
  logic        retire_valid;
  logic        commit_valid;
  commit_t     commit_out;
  logic        bp_valid;
  bp_update_t  bp_out;
  logic        store_release;
  logic        csr_retire;
  logic        exc_valid;
  exc_t        exc_out;
  logic        flush_valid;
  pc_t         flush_pc;

  // scoreboard and captured retire events
  dispatch_t   sent_q [$];
  sb_rec_t     sb [$];
  sb_rec_t     mon_rec;
  commit_t     commit_q [$];
  bp_update_t  bp_q [$];
  exc_t        exc_q [$];
  pc_t         flush_q [$];
  int          done_cnt;
  int          ret_cnt;
  int          store_cnt;
  int          csr_cnt;

  int          check_cnt;
  int          err_cnt;
  int          misc_cnt;
  logic [31:0] rand_state;
  logic [31:0] data_of [ROB_DEPTH];

  tb_clock_gen clock_gen_inst (
    .clk   (clk),
    .reset (reset)
  );

  rob_core rob_core_inst (
    .clk            (clk),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_in    (dispatch_in),
    .alloc_valid    (alloc_valid),
    .alloc_robid    (alloc_robid),
    .rob_full       (rob_full),
    .wb_valid       (wb_valid),
    .wb_in          (wb_in),
    .csr_tvec       (csr_tvec),
    .retire_valid   (retire_valid),
    .commit_valid   (commit_valid),
    .commit_out     (commit_out),
    .bp_valid       (bp_valid),
    .bp_out         (bp_out),
    .store_release  (store_release),
    .csr_retire     (csr_retire),
    .exc_valid      (exc_valid),
    .exc_out        (exc_out),
    .flush_valid    (flush_valid),
    .flush_pc       (flush_pc)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  function automatic op_class_t op_of(input logic br, input logic jmp, input logic csr,
                                      input logic st, input logic inv);
    op_class_t op;
    op = '{is_branch: br, is_jump: jmp, is_csr: csr, is_store: st, br_invert: inv};
    return op;
  endfunction

  function automatic dispatch_t make_disp(input op_class_t op, input pc_t pc, input dest_t rd,
                                          input pc_t target, input logic bptaken,
                                          input logic error, input logic [1:0] ecause);
    dispatch_t   d;
    logic [31:0] r;
    r = next_rand();
    d = '{op: op, pc: pc, rd: rd, target: target, bptag: r[23:8],
          bptaken: bptaken, error: error, ecause: ecause};
    return d;
  endfunction

  task automatic check_commit(input string name, input commit_t got, input commit_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bp(input string name, input bp_update_t got, input bp_update_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_exc(input string name, input exc_t got, input exc_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input rob_id_t got, input rob_id_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // true when exactly the expected strobe was seen
  function automatic bit strobe_ok(input string test, input string sig, input int seen,
                                   input bit exp);
    check_cnt++;
    if (exp && seen != 1) begin
      misc_cnt++;
      $display("%s: expected one %s strobe but saw %0d", test, sig, seen);
    end else if (!exp && seen != 0) begin
      misc_cnt++;
      $display("%s: %s strobe appeared where none was expected", test, sig);
    end
    return exp && (seen == 1);
  endfunction

  // all tasks start and end 5 ns after a rising edge
  task automatic step();
    @(posedge clk);
    #5;
  endtask

  task automatic clear_events();
    sb.delete();
    commit_q.delete();
    bp_q.delete();
    exc_q.delete();
    flush_q.delete();
    done_cnt  = 0;
    ret_cnt   = 0;
    store_cnt = 0;
    csr_cnt   = 0;
  endtask

  task automatic dispatch_one(input dispatch_t d);
    dispatch_valid = 1'b1;
    dispatch_in    = d;
    sent_q.push_back(d);
    step();
    dispatch_valid = 1'b0;
  endtask

  task automatic write_back(input rob_id_t id, input logic err, input logic [4:0] cause,
                            input logic [31:0] data);
    wb_valid           = 1'b1;
    wb_in.robid        = id;
    wb_in.error        = err;
    wb_in.ecause       = cause;
    wb_in.result.data  = data;
    step();
    wb_valid = 1'b0;
  endtask

  task automatic wait_done(input int n, input int budget, input string test);
    int cycles;
    cycles = 0;
    while (done_cnt < n && cycles < budget) begin
      step();
      cycles++;
    end
    if (done_cnt < n) begin
      misc_cnt++;
      $display("%s: only %0d of %0d instructions retired in time", test, done_cnt, n);
    end
  endtask

  // one instruction through the whole path with expectations from the retire rules
  task automatic run_one(input string test, input dispatch_t d, input logic do_wb,
                         input logic w_err, input logic [4:0] w_cause, input logic [31:0] w_data);
    logic        err;
    logic [4:0]  cause;
    logic [31:0] res;
    logic        taken;
    logic        mispred;
    pc_t         fpc;
    clear_events();
    dispatch_one(d);
    step();
    if (sb.size() != 1) begin
      misc_cnt++;
      $display("%s: dispatch was not allocated", test);
      return;
    end
    if (do_wb) begin
      write_back(sb[0].id, w_err, w_cause, w_data);
      err   = w_err;
      cause = w_cause;
      res   = w_data;
    end else begin
      err   = d.error;
      cause = {3'b000, d.ecause};
      res   = '0;
    end
    wait_done(1, BUDGET_ONE, test);
    repeat (3) step();
    taken   = res[0] ^ d.op.br_invert;
    mispred = d.op.is_jump | (d.op.is_branch & (taken != d.bptaken));
    if (err)
      fpc = csr_tvec;
    else if ((d.op.is_branch && taken) || d.op.is_jump)
      fpc = d.target;
    else
      fpc = d.pc + 30'd1;
    void'(strobe_ok(test, "retire_valid", ret_cnt, !err));
    if (strobe_ok(test, "commit_valid", commit_q.size(), !err && !d.rd[5]))
      check_commit("commit_out", commit_q[0], '{rd: d.rd[4:0], value: res});
    if (strobe_ok(test, "bp_valid", bp_q.size(), !err && d.op.is_branch))
      check_bp("bp_out", bp_q[0], '{bptag: d.bptag, taken: taken});
    void'(strobe_ok(test, "store_release", store_cnt, !err && d.op.is_store));
    void'(strobe_ok(test, "csr_retire", csr_cnt, !err && d.op.is_csr));
    if (strobe_ok(test, "exc_valid", exc_q.size(), err))
      check_exc("exc_out", exc_q[0], '{epc: d.pc, ecause: cause});
    if (strobe_ok(test, "flush_valid", flush_q.size(), err | mispred))
      check_pc("flush_pc", flush_q[0], fpc);
  endtask

  task automatic test_in_order();
    int          order [8];
    int          j;
    int          tmp;
    int          n_commit;
    logic [31:0] r;
    clear_events();
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      // a couple of entries without a destination
      dispatch_one(make_disp(op_of(0, 0, 0, 0, 0), 30'h200 + 30'(i),
                             {(i == 2 || i == 5), r[4:0]}, '0, 1'b0, 1'b0, 2'b00));
      data_of[i] = next_rand();
      order[i]   = i;
    end
    step();
    for (int i = 7; i > 0; i--) begin
      r        = next_rand();
      j        = int'(r[15:0]) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int k = 0; k < 8; k++)
      write_back(sb[order[k]].id, 1'b0, 5'd0, data_of[order[k]]);
    wait_done(8, BUDGET_ORDER, "in order");
    repeat (3) step();
    n_commit = 0;
    for (int i = 0; i < sb.size(); i++) begin
      if (!sb[i].d.rd[5]) begin
        if (n_commit < commit_q.size())
          check_commit("commit_out", commit_q[n_commit],
                       '{rd: sb[i].d.rd[4:0], value: data_of[i]});
        n_commit++;
      end
    end
    check_count("commit count", commit_q.size(), n_commit);
    check_count("flush count", flush_q.size(), 0);
  endtask

  task automatic test_branches();
    logic [31:0] r;
    r = next_rand();
    // predicted taken and taken
    run_one("branch predicted", make_disp(op_of(1, 0, 0, 0, 0), 30'h100, 6'h20, 30'h180,
            1'b1, 1'b0, 2'b00), 1'b1, 1'b0, 5'd0, {r[31:1], 1'b1});
    // inverted condition predicted not taken
    run_one("branch inverted", make_disp(op_of(1, 0, 0, 0, 1), 30'h110, 6'h20, 30'h190,
            1'b0, 1'b0, 2'b00), 1'b1, 1'b0, 5'd0, {r[31:1], 1'b1});
    run_one("branch mispredict taken", make_disp(op_of(1, 0, 0, 0, 0), 30'h120, 6'h20,
            30'h1a0, 1'b0, 1'b0, 2'b00), 1'b1, 1'b0, 5'd0, {r[31:1], 1'b1});
    run_one("branch mispredict not taken", make_disp(op_of(1, 0, 0, 0, 0), 30'h130, 6'h20,
            30'h1b0, 1'b1, 1'b0, 2'b00), 1'b1, 1'b0, 5'd0, {r[31:1], 1'b0});
  endtask

  task automatic test_squash();
    dispatch_t   jmp;
    logic [31:0] jdata;
    clear_events();
    jmp = make_disp(op_of(0, 1, 0, 0, 0), 30'h300, 6'h01, 30'h340, 1'b1, 1'b0, 2'b00);
    dispatch_one(jmp);
    dispatch_one(make_disp(op_of(0, 0, 0, 0, 0), 30'h301, 6'h02, '0, 1'b0, 1'b0, 2'b00));
    dispatch_one(make_disp(op_of(0, 0, 0, 0, 0), 30'h302, 6'h03, '0, 1'b0, 1'b0, 2'b00));
    step();
    // younger results arrive before the jump
    write_back(sb[1].id, 1'b0, 5'd0, next_rand());
    write_back(sb[2].id, 1'b0, 5'd0, next_rand());
    jdata = next_rand();
    write_back(sb[0].id, 1'b0, 5'd0, jdata);
    wait_done(1, BUDGET_SQUASH, "squash");
    repeat (4) step();
    check_count("retired count", done_cnt, 1);
    if (strobe_ok("squash", "commit_valid", commit_q.size(), 1'b1))
      check_commit("commit_out", commit_q[0], '{rd: jmp.rd[4:0], value: jdata});
    if (strobe_ok("squash", "flush_valid", flush_q.size(), 1'b1))
      check_pc("flush_pc", flush_q[0], jmp.target);
    dispatch_one(make_disp(op_of(0, 0, 0, 0, 0), 30'h340, 6'h04, '0, 1'b0, 1'b0, 2'b00));
    step();
    if (sb.size() != 4) begin
      misc_cnt++;
      $display("squash: dispatch after the flush was not allocated");
    end else begin
      check_id("alloc_robid", sb[3].id, '0);
      write_back(sb[3].id, 1'b0, 5'd0, next_rand());
      wait_done(2, BUDGET_ONE, "squash");
      check_count("commit count", commit_q.size(), 2);
    end
  endtask

  task automatic test_full();
    int          count;
    logic [31:0] r;
    clear_events();
    count = 0;
    while (!rob_full && count < ROB_DEPTH + 4) begin
      r = next_rand();
      dispatch_valid = 1'b1;
      dispatch_in    = make_disp(op_of(0, 0, 0, 0, 0), 30'h1000 + 30'(count), {1'b0, r[4:0]},
                                 '0, 1'b0, 1'b0, 2'b00);
      sent_q.push_back(dispatch_in);
      step();
      count++;
    end
    dispatch_valid = 1'b0;
    // level rises with one slot left for the staged entry
    check_count("dispatches before rob_full", count, ROB_DEPTH);
    repeat (2) step();
    check_bit("rob_full", rob_full, 1'b1);
    for (int i = 0; i < sb.size(); i++) begin
      data_of[i] = next_rand();
      write_back(sb[i].id, 1'b0, 5'd0, data_of[i]);
    end
    wait_done(sb.size(), BUDGET_FULL, "full");
    repeat (3) step();
    check_count("commit count", commit_q.size(), sb.size());
    for (int i = 0; i < sb.size() && i < commit_q.size(); i++)
      check_commit("commit_out", commit_q[i], '{rd: sb[i].d.rd[4:0], value: data_of[i]});
    check_bit("rob_full", rob_full, 1'b0);
  endtask

  // retire and allocation monitor sampling on the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (alloc_valid) begin
        if (sent_q.size() == 0) begin
          misc_cnt++;
          $display("alloc_valid appeared with no dispatch outstanding");
        end else begin
          mon_rec.d  = sent_q.pop_front();
          mon_rec.id = alloc_robid;
          sb.push_back(mon_rec);
        end
      end
      if (retire_valid || exc_valid)
        done_cnt++;
      if (retire_valid)
        ret_cnt++;
      if (commit_valid)
        commit_q.push_back(commit_out);
      if (bp_valid)
        bp_q.push_back(bp_out);
      if (store_release)
        store_cnt++;
      if (csr_retire)
        csr_cnt++;
      if (exc_valid)
        exc_q.push_back(exc_out);
      if (flush_valid)
        flush_q.push_back(flush_pc);
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("simulation stopped by watchdog after %0d cycles", WD_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin
    dispatch_valid = 1'b0;
    dispatch_in    = '0;
    wb_valid       = 1'b0;
    wb_in          = '0;
    csr_tvec       = 30'h0000_3c10;
    rand_state     = 32'd7769;
    check_cnt      = 0;
    err_cnt        = 0;
    misc_cnt       = 0;
    clear_events();
    @(negedge reset);
    check_bit("alloc_valid", alloc_valid, 1'b0);
    check_bit("rob_full", rob_full, 1'b0);
    check_bit("retire_valid", retire_valid, 1'b0);
    check_bit("commit_valid", commit_valid, 1'b0);
    check_bit("bp_valid", bp_valid, 1'b0);
    check_bit("store_release", store_release, 1'b0);
    check_bit("csr_retire", csr_retire, 1'b0);
    check_bit("exc_valid", exc_valid, 1'b0);
    check_bit("flush_valid", flush_valid, 1'b0);
    test_in_order();
    test_branches();
    test_squash();
    run_one("decode error", make_disp(op_of(0, 0, 0, 0, 0), 30'h400, 6'h07, '0, 1'b0,
            1'b1, 2'd2), 1'b0, 1'b0, 5'd0, '0);
    run_one("writeback error", make_disp(op_of(0, 0, 0, 0, 0), 30'h410, 6'h09, '0, 1'b0,
            1'b0, 2'd0), 1'b1, 1'b1, 5'h0d, next_rand());
    run_one("store", make_disp(op_of(0, 0, 0, 1, 0), 30'h420, 6'h20, '0, 1'b0, 1'b0, 2'd0),
            1'b0, 1'b0, 5'd0, '0);
    run_one("csr", make_disp(op_of(0, 0, 1, 0, 0), 30'h430, 6'h0a, '0, 1'b0, 1'b0, 2'd0),
            1'b1, 1'b0, 5'd0, next_rand());
    test_full();
    $display("checks run %0d, value errors %0d, other errors %0d", check_cnt, err_cnt, misc_cnt);
    if (err_cnt == 0 && misc_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
// testbench clock and reset source, 100 ns period with reset held for 8 cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // release lands on the stimulus offset after the 8th edge
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #5;
    reset = 1'b0;
  end

endmodule

// File: rob_core.sv
// reorder buffer top joining dispatch stage, entry storage and retire decoder
`timescale 1ns/1ps

module rob_core (
  input  logic                clk,
  input  logic                reset,

  // dispatch side
  input  logic                dispatch_valid,
  input  rob_pkg::dispatch_t  dispatch_in,
  output logic                alloc_valid,
  output rob_pkg::rob_id_t    alloc_robid,
  output logic                rob_full,

  // writeback side
  input  logic                wb_valid,
  input  rob_pkg::wb_t        wb_in,

  // trap vector from csr file
  input  rob_pkg::pc_t        csr_tvec,

  // retire side
  output logic                retire_valid,
  output logic                commit_valid,
  output rob_pkg::commit_t    commit_out,
  output logic                bp_valid,
  output rob_pkg::bp_update_t bp_out,
  output logic                store_release,
  output logic                csr_retire,
  output logic                exc_valid,
  output rob_pkg::exc_t       exc_out,
  output logic                flush_valid,
  output rob_pkg::pc_t        flush_pc
);

  import rob_pkg::*;

  rob_entry_t alloc_entry;
  logic       head_valid;
  retire_t    head_entry;
  logic       flush;

  rob_dispatch rob_dispatch_inst (
    .clk            (clk),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_in    (dispatch_in),
    .flush          (flush),
    .rob_full       (rob_full),
    .alloc_valid    (alloc_valid),
    .alloc_entry    (alloc_entry)
  );

  rob_buffer rob_buffer_inst (
    .clk         (clk),
    .reset       (reset),
    .alloc_valid (alloc_valid),
    .alloc_entry (alloc_entry),
    .wb_valid    (wb_valid),
    .wb_in       (wb_in),
    .flush       (flush),
    .alloc_robid (alloc_robid),
    .rob_full    (rob_full),
    .head_valid  (head_valid),
    .head_entry  (head_entry)
  );

  rob_retire rob_retire_inst (
    .clk           (clk),
    .reset         (reset),
    .head_valid    (head_valid),
    .head_entry    (head_entry),
    .csr_tvec      (csr_tvec),
    .flush         (flush),
    .retire_valid  (retire_valid),
    .commit_valid  (commit_valid),
    .commit_out    (commit_out),
    .bp_valid      (bp_valid),
    .bp_out        (bp_out),
    .store_release (store_release),
    .csr_retire    (csr_retire),
    .exc_valid     (exc_valid),
    .exc_out       (exc_out),
    .flush_valid   (flush_valid),
    .flush_pc      (flush_pc)
  );

endmodule

// File: rob_retire.sv
// retire decoder that turns the head entry into commit, branch, store, csr, trap and flush events
`timescale 1ns/1ps

module rob_retire (
  input  logic                clk,
  input  logic                reset,

  // head entry from buffer
  input  logic                head_valid,
  input  rob_pkg::retire_t    head_entry,
  input  rob_pkg::pc_t        csr_tvec,

  // same-cycle flush to buffer and dispatch
  output logic                flush,

  // registered retire events
  output logic                retire_valid,
  output logic                commit_valid,
  output rob_pkg::commit_t    commit_out,
  output logic                bp_valid,
  output rob_pkg::bp_update_t bp_out,
  output logic                store_release,
  output logic                csr_retire,
  output logic                exc_valid,
  output rob_pkg::exc_t       exc_out,
  output logic                flush_valid,
  output rob_pkg::pc_t        flush_pc
);

  import rob_pkg::*;

  logic br_result;
  logic br_taken;
  logic mispred;
  logic exc;
  logic ret_ok;
  pc_t  redirect_pc;

  // branch units report the raw compare, invert for bne-style ops
  assign br_result = head_entry.result.branch.cond ^ head_entry.op.br_invert;
  assign br_taken  = head_entry.op.is_branch & br_result;

  assign mispred = head_valid &
                   (head_entry.op.is_jump |
                    (head_entry.op.is_branch & (br_result != head_entry.bptaken)));
  assign exc     = head_valid & head_entry.error;
  assign flush   = exc | mispred;
  assign ret_ok  = head_valid & ~head_entry.error;

  always_comb begin
    if (head_entry.error) begin
      redirect_pc = csr_tvec;
    end else if (br_taken || head_entry.op.is_jump) begin
      redirect_pc = head_entry.target;
    end else begin
      // fall through
      redirect_pc = head_entry.pc + 1'b1;
    end
  end

  // event strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid  <= 1'b0;
      commit_valid  <= 1'b0;
      bp_valid      <= 1'b0;
      store_release <= 1'b0;
      csr_retire    <= 1'b0;
      exc_valid     <= 1'b0;
      flush_valid   <= 1'b0;
    end else begin
      retire_valid  <= ret_ok;
      commit_valid  <= ret_ok & ~head_entry.rd[5];
      bp_valid      <= ret_ok & head_entry.op.is_branch;
      store_release <= ret_ok & head_entry.op.is_store;
      csr_retire    <= ret_ok & head_entry.op.is_csr;
      exc_valid     <= exc;
      flush_valid   <= flush;
    end
  end

  // event payloads
  always_ff @(posedge clk) begin
    commit_out <= '{rd: head_entry.rd[4:0], value: head_entry.result.data};
    bp_out     <= '{bptag: head_entry.bptag, taken: br_result};
    exc_out    <= '{epc: head_entry.pc, ecause: head_entry.ecause};
    flush_pc   <= redirect_pc;
  end

  // a trapping entry must not also count as retired
  a_exc_not_retired: assert property (
    @(posedge clk) disable iff (reset)
    !(exc_valid && retire_valid)
  ) else $error("exception and retirement in the same cycle");

endmodule

// File: rob_buffer.sv
// circular reorder storage with writeback by slot id and read-ahead head register
`timescale 1ns/1ps

module rob_buffer (
  input  logic                clk,
  input  logic                reset,

  // allocation from dispatch
  input  logic                alloc_valid,
  input  rob_pkg::rob_entry_t alloc_entry,

  // results from execution units
  input  logic                wb_valid,
  input  rob_pkg::wb_t        wb_in,

  // from retire
  input  logic                flush,

  output rob_pkg::rob_id_t    alloc_robid,
  output logic                rob_full,

  // head entry to retire
  output logic                head_valid,
  output rob_pkg::retire_t    head_entry
);

  import rob_pkg::*;

  rob_entry_t mem [ROB_DEPTH];

  // insert at tail, retire from head
  rob_ptr_t head;
  rob_ptr_t tail;

  rob_ptr_t   head_next;
  rob_ptr_t   rd_ptr;
  rob_id_t    rd_addr;
  logic       rd_empty;
  rob_ptr_t   used;
  logic       buf_full;
  rob_entry_t rd_entry;
  rob_id_t    wb_off;

  assign head_next = head + 1'b1;

  // look past the entry being retired so back-to-back entries flow
  assign rd_ptr   = head_valid ? head_next : head;
  assign rd_addr  = rd_ptr[ROB_ID_W-1:0];
  assign rd_empty = (rd_ptr == tail);
  assign rd_entry = mem[rd_addr];

  // occupancy, wrap bit makes 128 distinct from 0
  assign used     = tail - head;
  assign buf_full = (head[ROB_ID_W-1:0] == tail[ROB_ID_W-1:0]) &&
                    (head[ROB_ID_W] != tail[ROB_ID_W]);

  // one slot of margin for the entry sitting in dispatch
  assign rob_full = (used >= rob_ptr_t'(ROB_DEPTH - 1));

  assign alloc_robid = tail[ROB_ID_W-1:0];

  // head pointer
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      head <= '0;
    end else if (head_valid) begin
      head <= head_next;
    end
  end

  // tail pointer
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      tail <= '0;
    end else if (alloc_valid) begin
      tail <= tail + 1'b1;
    end
  end

  // storage writes, allocation and writeback never hit the same slot
  always_ff @(posedge clk) begin
    if (alloc_valid) begin
      mem[tail[ROB_ID_W-1:0]] <= alloc_entry;
    end
    if (wb_valid) begin
      mem[wb_in.robid].executed <= 1'b1;
      mem[wb_in.robid].error    <= wb_in.error;
      mem[wb_in.robid].ecause   <= wb_in.ecause;
      mem[wb_in.robid].result   <= wb_in.result;
    end
  end

  // head valid, retire waits for execution
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      head_valid <= 1'b0;
    end else begin
      head_valid <= rd_entry.executed && !rd_empty;
    end
  end

  // head payload
  always_ff @(posedge clk) begin
    head_entry <= '{
      op:      rd_entry.op,
      pc:      rd_entry.pc,
      rd:      rd_entry.rd,
      target:  rd_entry.target,
      bptag:   rd_entry.bptag,
      bptaken: rd_entry.bptaken,
      error:   rd_entry.error,
      ecause:  rd_entry.ecause,
      result:  rd_entry.result
    };
  end

  // distance of the written slot from head
  assign wb_off = wb_in.robid - head[ROB_ID_W-1:0];

  // results only land in slots between head and tail
  a_wb_in_range: assert property (
    @(posedge clk) disable iff (reset)
    wb_valid |-> ({1'b0, wb_off} < used)
  ) else $error("writeback to unallocated slot %0h", wb_in.robid);

  // the full margin keeps the staged entry from overrunning the head
  a_no_alloc_when_full: assert property (
    @(posedge clk) disable iff (reset)
    !(alloc_valid && buf_full)
  ) else $error("allocation into a full buffer");

endmodule

// File: rob_dispatch.sv
// dispatch stage that holds a decoded instruction one cycle and forms its buffer entry
`timescale 1ns/1ps

module rob_dispatch (
  input  logic                clk,
  input  logic                reset,

  // decoded instruction strobe, no stall
  input  logic                dispatch_valid,
  input  rob_pkg::dispatch_t  dispatch_in,

  // from retire and buffer
  input  logic                flush,
  input  logic                rob_full,

  // to buffer
  output logic                alloc_valid,
  output rob_pkg::rob_entry_t alloc_entry
);

  import rob_pkg::*;

  dispatch_t staged;

  // strobe register, dropped on a pipeline flush
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      alloc_valid <= 1'b0;
    end else begin
      alloc_valid <= dispatch_valid;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (dispatch_valid) begin
      staged <= dispatch_in;
    end
  end

  // initial entry
  always_comb begin
    alloc_entry.op      = staged.op;
    alloc_entry.pc      = staged.pc;
    alloc_entry.rd      = staged.rd;
    alloc_entry.target  = staged.target;
    alloc_entry.bptag   = staged.bptag;
    alloc_entry.bptaken = staged.bptaken;
    alloc_entry.error   = staged.error;
    // decode cause fits in the low bits
    alloc_entry.ecause  = {3'b000, staged.ecause};
    // stores execute at dispatch, decode errors never reach an execution unit
    alloc_entry.executed = staged.error | staged.op.is_store;
    alloc_entry.result   = '0;
  end

  // no stall on the strobe, so the sender must honour the full level
  a_no_dispatch_when_full: assert property (
    @(posedge clk) disable iff (reset)
    !(dispatch_valid && rob_full)
  ) else $error("dispatch strobe while rob_full is high");

endmodule

// File: rob_pkg.sv
// reorder buffer package with shared widths, entry types and retire port types
package rob_pkg;

  // buffer geometry
  localparam int ROB_DEPTH = 128;
  localparam int ROB_ID_W  = 7;

  // field widths
  localparam int PC_W     = 30;
  localparam int BPTAG_W  = 16;
  localparam int ECAUSE_W = 5;

  typedef logic [ROB_ID_W-1:0] rob_id_t;

  // slot index plus wrap polarity in the top bit
  typedef logic [ROB_ID_W:0] rob_ptr_t;

  // word address, byte bits dropped
  typedef logic [PC_W-1:0] pc_t;

  typedef struct packed {
    logic is_branch;
    logic is_jump;
    logic is_csr;
    logic is_store;
    logic br_invert;
  } op_class_t;

  // top bit set means no destination register
  typedef logic [5:0] dest_t;

  typedef struct packed {
    op_class_t           op;
    pc_t                 pc;
    dest_t               rd;
    pc_t                 target;
    logic [BPTAG_W-1:0]  bptag;
    logic                bptaken;
    logic                error;
    logic [1:0]          ecause;
  } dispatch_t;

  // branch units return the condition in bit 0 of the same word
  typedef struct packed {
    logic [30:0] unused;
    logic        cond;
  } br_view_t;

  typedef union packed {
    logic [31:0] data;
    br_view_t    branch;
  } rob_result_u;

  typedef struct packed {
    rob_id_t             robid;
    logic                error;
    logic [ECAUSE_W-1:0] ecause;
    rob_result_u         result;
  } wb_t;

  typedef struct packed {
    op_class_t           op;
    pc_t                 pc;
    dest_t               rd;
    pc_t                 target;
    logic [BPTAG_W-1:0]  bptag;
    logic                bptaken;
    logic                error;
    logic [ECAUSE_W-1:0] ecause;
    logic                executed;
    rob_result_u         result;
  } rob_entry_t;

  // head entry as seen by retire
  typedef struct packed {
    op_class_t           op;
    pc_t                 pc;
    dest_t               rd;
    pc_t                 target;
    logic [BPTAG_W-1:0]  bptag;
    logic                bptaken;
    logic                error;
    logic [ECAUSE_W-1:0] ecause;
    rob_result_u         result;
  } retire_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] value;
  } commit_t;

  typedef struct packed {
    logic [BPTAG_W-1:0] bptag;
    logic               taken;
  } bp_update_t;

  typedef struct packed {
    pc_t                 epc;
    logic [ECAUSE_W-1:0] ecause;
  } exc_t;

endpackage
